/* bch_consts.svh */
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// Code length, message length and correction capability.
`define BCH_N 15
`define BCH_K 5
`define BCH_T 3

// Field GF(2^4).
`define GF_M 4

// Primitive polynomial x^4+x+1.
`define GF_POLY 5'b10011

// Generator polynomial x^10+x^8+x^5+x^4+x^2+x+1.
// The message sits in bits 14..10 of the systematic word.
`define BCH_GEN 11'b10100110111

`endif

/* logic/bchDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bchDecoder (
	input wire clk,
	input wire rst,
	input wire inReq,
	input wire decoderPkg::codeWord inData,
	output logic inAck,
	output logic outReq,
	output decoderPkg::message outMsg,
	output logic outFail,
	input wire outAck
);

	logic synBusy;
	logic synStart;
	logic bitValid;
	logic serBit;
	logic locBusy;
	logic locStart;
	logic chienBusy;
	logic chienStart;
	decoderPkg::codeWord feedWord;
	decoderPkg::codeWord synWord;
	decoderPkg::codeWord locWord;
	decoderPkg::syndromeSet syndromes;
	decoderPkg::locatorPoly lambda;
	decoderPkg::locDegree degree;

	codewordIn codewordIn_inst (
		.clk(clk), .rst(rst), .inReq(inReq), .inData(inData), .inAck(inAck),
		.synBusy(synBusy), .synStart(synStart), .bitValid(bitValid),
		.serBit(serBit), .word(feedWord)
	);

	syndromeCalc syndromeCalc_inst (
		.clk(clk), .rst(rst), .synStart(synStart), .bitValid(bitValid),
		.serBit(serBit), .word(feedWord), .synBusy(synBusy), .locBusy(locBusy),
		.locStart(locStart), .syndromes(syndromes), .wordOut(synWord)
	);

	errorLocator errorLocator_inst (
		.clk(clk), .rst(rst), .locStart(locStart), .syndromes(syndromes),
		.word(synWord), .locBusy(locBusy), .chienBusy(chienBusy),
		.chienStart(chienStart), .lambda(lambda), .degree(degree), .wordOut(locWord)
	);

	chienCorrect chienCorrect_inst (
		.clk(clk), .rst(rst), .chienStart(chienStart), .lambda(lambda),
		.degree(degree), .word(locWord), .chienBusy(chienBusy), .outReq(outReq),
		.outAck(outAck), .outMsg(outMsg), .outFail(outFail)
	);

endmodule

`default_nettype wire

/* logic/chienCorrect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bch_consts.svh"

module chienCorrect (
	input wire clk,
	input wire rst,
	input wire chienStart,
	input wire decoderPkg::locatorPoly lambda,
	input wire decoderPkg::locDegree degree,
	input wire decoderPkg::codeWord word,
	output logic chienBusy,
	output logic outReq,
	input wire outAck,
	output decoderPkg::message outMsg,
	output logic outFail
);

	localparam int M = `GF_M;
	localparam int NumCoef = 2 * `BCH_T + 1;
	localparam logic [3:0] LastStep = 4'(`BCH_N);

	decoderPkg::hsState sendState;
	decoderPkg::locatorPoly terms;
	decoderPkg::locatorPoly termsNext;
	decoderPkg::codeWord origWord;
	decoderPkg::codeWord fixedWord;
	decoderPkg::locDegree degReg;
	gfPkg::gfElem evalSum;
	logic [3:0] stepK;
	logic [3:0] rootCount;
	logic [3:0] flipPos;
	logic searching;
	logic deciding;
	logic isRoot;
	logic failNow;
	logic accept;

	assign chienBusy = searching || deciding || (sendState != decoderPkg::hsIdle);
	assign accept = chienStart && !chienBusy;
	assign flipPos = (stepK == LastStep) ? 4'd0 : LastStep - stepK; // (15 - k) mod 15.
	assign failNow = (degReg > 3'(`BCH_T)) || (rootCount != {1'b0, degReg});

	// Lambda(alpha^k) from the stepped terms.
	always_comb begin
		evalSum = '0;
		for (int j = 0; j < NumCoef; j++) begin
			termsNext[j*M +: M] = gfPkg::gfMul(terms[j*M +: M], gfPkg::gfAlphaPow(M'(j)));
			evalSum = evalSum ^ termsNext[j*M +: M];
		end
		isRoot = (evalSum == '0);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			searching <= 1'b0;
			deciding <= 1'b0;
			sendState <= decoderPkg::hsIdle;
			outReq <= 1'b0;
			stepK <= '0;
			rootCount <= '0;
		end else begin
			if (accept) begin
				searching <= 1'b1;
				stepK <= 4'd1;
				rootCount <= '0;
			end else if (searching) begin
				stepK <= stepK + 4'd1;
				if (isRoot)
					rootCount <= rootCount + 4'd1;
				if (stepK == LastStep) begin
					searching <= 1'b0;
					deciding <= 1'b1;
				end
			end else if (deciding) begin
				deciding <= 1'b0;
				outReq <= 1'b1;
				sendState <= decoderPkg::hsAssert;
			end
			case (sendState)
				decoderPkg::hsAssert: begin
					if (outAck) begin
						outReq <= 1'b0;
						sendState <= decoderPkg::hsRelease;
					end
				end
				decoderPkg::hsRelease: begin
					if (!outAck)
						sendState <= decoderPkg::hsIdle; // Transfer done.
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			terms <= lambda;
			degReg <= degree;
			origWord <= word;
			fixedWord <= word;
		end else if (searching) begin
			terms <= termsNext;
			if (isRoot)
				fixedWord[flipPos] <= ~fixedWord[flipPos];
		end else if (deciding) begin
			outFail <= failNow;
			outMsg <= failNow ? origWord[`BCH_N-1 -: `BCH_K] : fixedWord[`BCH_N-1 -: `BCH_K];
		end
	end

	// Result must not move under a pending request.
	assert property (@(posedge clk) disable iff (rst)
		outReq |=> $stable(outMsg) && $stable(outFail))
		else $error("outMsg changed while outReq high");

endmodule

`default_nettype wire

/* logic/codewordIn.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bch_consts.svh"

module codewordIn (
	input wire clk,
	input wire rst,
	input wire inReq,
	input wire decoderPkg::codeWord inData,
	output logic inAck,
	input wire synBusy,
	output logic synStart,
	output logic bitValid,
	output logic serBit,
	output decoderPkg::codeWord word
);

	localparam logic [3:0] LastBit = 4'(`BCH_N - 1);

	decoderPkg::hsState recvState;
	decoderPkg::codeWord capWord;
	decoderPkg::codeWord shiftWord;
	logic capFull;
	logic [3:0] bitCount;
	logic feedGo;
	logic capture;

	assign capture = (recvState == decoderPkg::hsIdle) && inReq && !capFull;
	assign feedGo = capFull && !synBusy && !synStart && !bitValid;
	assign serBit = shiftWord[`BCH_N-1]; // MSB first.

	always_ff @(posedge clk) begin
		if (rst) begin
			recvState <= decoderPkg::hsIdle;
			inAck <= 1'b0;
			capFull <= 1'b0;
			synStart <= 1'b0;
			bitValid <= 1'b0;
			bitCount <= '0;
		end else begin
			case (recvState)
				decoderPkg::hsIdle: begin
					if (capture) begin
						inAck <= 1'b1;
						capFull <= 1'b1; // Held until fed.
						recvState <= decoderPkg::hsAssert;
					end
				end
				decoderPkg::hsAssert: begin
					if (!inReq) begin
						inAck <= 1'b0;
						recvState <= decoderPkg::hsRelease;
					end
				end
				default: recvState <= decoderPkg::hsIdle;
			endcase
			synStart <= feedGo;
			if (feedGo)
				capFull <= 1'b0;
			if (synStart) begin
				bitValid <= 1'b1;
				bitCount <= '0;
			end else if (bitValid) begin
				bitCount <= bitCount + 4'd1;
				if (bitCount == LastBit)
					bitValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			capWord <= inData;
		if (feedGo) begin
			shiftWord <= capWord;
			word <= capWord; // Travels with the word downstream.
		end else if (bitValid) begin
			shiftWord <= shiftWord << 1;
		end
	end

	// The environment must already be requesting when ack goes up.
	assert property (@(posedge clk) disable iff (rst) $rose(inAck) |-> $past(inReq))
		else $error("inAck rose without inReq");

endmodule

`default_nettype wire

/* logic/decoderPkg.sv */
`default_nettype none

`include "bch_consts.svh"

package decoderPkg;

	typedef logic [`BCH_N-1:0] codeWord; // Bit i is coefficient of x^i.
	typedef logic [`BCH_K-1:0] message; // Bits 14..10 of the word.

	// S1 in the low nibble, S6 in the high one.
	typedef logic [2*`BCH_T*`GF_M-1:0] syndromeSet;

	// Lambda0 in the low nibble, Lambda6 in the high one.
	typedef logic [(2*`BCH_T+1)*`GF_M-1:0] locatorPoly;

	typedef logic [2:0] locDegree;

	// Shared by the receive and send sides.
	typedef enum logic [1:0] {hsIdle, hsAssert, hsRelease} hsState;

	typedef enum logic [1:0] {bmIdle, bmIterate, bmDone} bmState;

endpackage

`default_nettype wire

/* logic/errorLocator.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bch_consts.svh"

module errorLocator (
	input wire clk,
	input wire rst,
	input wire locStart,
	input wire decoderPkg::syndromeSet syndromes,
	input wire decoderPkg::codeWord word,
	output logic locBusy,
	input wire chienBusy,
	output logic chienStart,
	output decoderPkg::locatorPoly lambda,
	output decoderPkg::locDegree degree,
	output decoderPkg::codeWord wordOut
);

	localparam int M = `GF_M;
	localparam int NumSyn = 2 * `BCH_T;
	localparam int NumCoef = NumSyn + 1;
	localparam logic [2:0] LastIter = 3'(NumSyn - 1);

	decoderPkg::bmState state;
	decoderPkg::syndromeSet synReg;
	decoderPkg::locatorPoly auxPoly;
	decoderPkg::locatorPoly lamNext;
	decoderPkg::locDegree lenL;
	gfPkg::gfElem gamma;
	gfPkg::gfElem delta;
	logic [2:0] iter;
	logic grow;
	logic accept;

	assign locBusy = (state != decoderPkg::bmIdle);
	assign accept = (state == decoderPkg::bmIdle) && locStart;
	assign degree = lenL;

	// Discrepancy is the sum of Lambda_i * S_(r+1-i).
	always_comb begin : discrepancy
		int synIdx;
		delta = '0;
		for (int i = 0; i < NumCoef; i++) begin
			synIdx = int'(iter) + 1 - i;
			if (synIdx >= 1 && synIdx <= NumSyn)
				delta = delta ^ gfPkg::gfMul(lambda[i*M +: M], synReg[(synIdx-1)*M +: M]);
		end
	end

	// Lambda' = gamma * Lambda + delta * x * B.
	always_comb begin
		grow = (delta != '0) && ({lenL, 1'b0} <= {1'b0, iter});
		for (int i = 0; i < NumCoef; i++) begin
			lamNext[i*M +: M] = gfPkg::gfMul(gamma, lambda[i*M +: M]);
			if (i > 0)
				lamNext[i*M +: M] = lamNext[i*M +: M]
					^ gfPkg::gfMul(delta, auxPoly[(i-1)*M +: M]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= decoderPkg::bmIdle;
			chienStart <= 1'b0;
			iter <= '0;
		end else begin
			case (state)
				decoderPkg::bmIdle: begin
					if (locStart) begin
						state <= decoderPkg::bmIterate;
						iter <= '0;
					end
				end
				decoderPkg::bmIterate: begin
					iter <= iter + 3'd1;
					if (iter == LastIter)
						state <= decoderPkg::bmDone;
				end
				decoderPkg::bmDone: begin
					if (chienStart) begin
						chienStart <= 1'b0;
						state <= decoderPkg::bmIdle;
					end else if (!chienBusy) begin
						chienStart <= 1'b1; // Chien side free.
					end
				end
				default: state <= decoderPkg::bmIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			synReg <= syndromes;
			wordOut <= word;
			lambda <= decoderPkg::locatorPoly'(1);
			auxPoly <= decoderPkg::locatorPoly'(1);
			gamma <= gfPkg::gfElem'(1);
			lenL <= '0;
		end else if (state == decoderPkg::bmIterate) begin
			lambda <= lamNext;
			if (grow) begin
				auxPoly <= lambda; // Old locator becomes B.
				gamma <= delta;
				lenL <= iter + 3'd1 - lenL;
			end else begin
				auxPoly <= auxPoly << M; // B = x * B.
			end
		end
	end

	// Length stays within the register file of seven coefficients.
	assert property (@(posedge clk) disable iff (rst)
		state == decoderPkg::bmIterate |=> lenL <= 3'd6)
		else $error("Locator length above 6");

endmodule

`default_nettype wire

/* logic/gfPkg.sv */
`default_nettype none

`include "bch_consts.svh"

package gfPkg;

	typedef logic [`GF_M-1:0] gfElem; // Polynomial basis.

	// Multiply by alpha, reducing by the primitive polynomial.
	function automatic gfElem gfMulAlpha(input gfElem a);
		logic [`GF_M:0] poly;
		poly = `GF_POLY;
		if (a[`GF_M-1])
			return (a << 1) ^ poly[`GF_M-1:0];
		return a << 1;
	endfunction

	// Shift-and-add product.
	function automatic gfElem gfMul(input gfElem a, input gfElem b);
		gfElem acc;
		gfElem shifted;
		acc = '0;
		shifted = a;
		for (int i = 0; i < `GF_M; i++) begin
			if (b[i])
				acc = acc ^ shifted;
			shifted = gfMulAlpha(shifted);
		end
		return acc;
	endfunction

	// Alpha^power for power 0..14.
	function automatic gfElem gfAlphaPow(input logic [`GF_M-1:0] power);
		gfElem result;
		result = gfElem'(1);
		for (int i = 0; i < `BCH_N - 1; i++) begin
			if (i < int'(power))
				result = gfMulAlpha(result);
		end
		return result;
	endfunction

endpackage

`default_nettype wire

/* logic/syndromeCalc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bch_consts.svh"

module syndromeCalc (
	input wire clk,
	input wire rst,
	input wire synStart,
	input wire bitValid,
	input wire serBit,
	input wire decoderPkg::codeWord word,
	output logic synBusy,
	input wire locBusy,
	output logic locStart,
	output decoderPkg::syndromeSet syndromes,
	output decoderPkg::codeWord wordOut
);

	localparam int M = `GF_M;
	localparam int NumSyn = 2 * `BCH_T;
	localparam logic [3:0] LastBit = 4'(`BCH_N - 1);

	logic [3:0] bitCount;
	logic ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			synBusy <= 1'b0;
			ready <= 1'b0;
			locStart <= 1'b0;
			bitCount <= '0;
		end else begin
			if (synStart) begin
				synBusy <= 1'b1;
				ready <= 1'b0;
				bitCount <= '0;
			end else if (bitValid) begin
				bitCount <= bitCount + 4'd1;
				if (bitCount == LastBit)
					ready <= 1'b1; // All 15 bits absorbed.
			end else if (locStart) begin
				locStart <= 1'b0;
				ready <= 1'b0;
				synBusy <= 1'b0;
			end else if (ready && !locBusy) begin
				locStart <= 1'b1;
			end
		end
	end

	// Each bit does one Horner step S_j = S_j * alpha^j + r_i.
	always_ff @(posedge clk) begin
		if (synStart) begin
			syndromes <= '0;
			wordOut <= word;
		end else if (bitValid) begin
			for (int j = 1; j <= NumSyn; j++) begin
				syndromes[(j-1)*M +: M] <=
					gfPkg::gfMul(syndromes[(j-1)*M +: M], gfPkg::gfAlphaPow(M'(j)))
					^ gfPkg::gfElem'(serBit);
			end
		end
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the BCH decoder testbench, then judge the log.
rm -f sim.log
verilator --binary --timing --assert --top-module bchDecoderTb -f sources.f \
	-o bchDecoderSim > build.log 2>&1 \
	|| { cat build.log; exit 1; }
./obj_dir/bchDecoderSim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* sources.f */
+incdir+.
logic/gfPkg.sv
logic/decoderPkg.sv
logic/codewordIn.sv
logic/syndromeCalc.sv
logic/errorLocator.sv
logic/chienCorrect.sv
logic/bchDecoder.sv
test/bchDecoderTb.sv

/* test/bchDecoderTb.sv */
`timescale 1ns/1ps
`default_nettype none

module bchDecoderTb;

	localparam int TimeoutCycles = 200; // Per wait.
	localparam int MaxInFlight = 4; // Capture, syndrome, locator, Chien.

	logic clk;
	logic rst;
	logic inReq;
	decoderPkg::codeWord inData;
	logic inAck;
	logic outReq;
	decoderPkg::message outMsg;
	logic outFail;
	logic outAck;

	decoderPkg::codeWord wordQ[$];
	decoderPkg::message msgQ[$];
	logic failQ[$];
	int mismatchCount = 0;
	int otherCount = 0;
	int sentCount = 0;
	int gotCount = 0;
	bit overflowSeen = 1'b0;

	bchDecoder bchDecoder_inst (
		.clk(clk), .rst(rst), .inReq(inReq), .inData(inData), .inAck(inAck),
		.outReq(outReq), .outMsg(outMsg), .outFail(outFail), .outAck(outAck)
	);

	always #10 clk = ~clk; // 20 ns period.

	// Registered outputs have settled 2 ns after the edge.
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic waitForLevel(input bit onOutput, input logic level, input string name,
			output bit ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < TimeoutCycles) begin
			if ((onOutput ? outReq : inAck) === level) begin
				ok = 1'b1;
			end else begin
				nextCycle();
				cycles++;
			end
		end
		if (!ok) begin
			otherCount++;
			$display("timeout at %0t ns: %s did not reach %0d within %0d cycles",
				$time, name, level, TimeoutCycles);
		end
	endtask

	task automatic checkMessage(input int caseIdx, input decoderPkg::message expected,
			input decoderPkg::message actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("mismatch at %0t ns: outMsg case %0d expected %h got %h",
				$time, caseIdx, expected, actual);
		end
	endtask

	task automatic checkFail(input int caseIdx, input logic expected, input logic actual);
		if (actual !== expected) begin
			mismatchCount++;
			$display("mismatch at %0t ns: outFail case %0d expected %b got %b",
				$time, caseIdx, expected, actual);
		end
	endtask

	task automatic readTrace();
		int fd;
		int fields;
		logic [8*96-1:0] lineText;
		logic [31:0] w;
		logic [31:0] m;
		logic [31:0] f;
		fd = $fopen("test/decode_trace.txt", "r");
		if (fd == 0) begin
			otherCount++;
			$display("could not open the trace file test/decode_trace.txt");
			return;
		end
		while (!$feof(fd)) begin
			lineText = '0;
			if ($fgets(lineText, fd) > 0) begin
				fields = $sscanf(lineText, "%h %h %h", w, m, f);
				if (fields == 3) begin // Comment lines match nothing.
					wordQ.push_back(decoderPkg::codeWord'(w));
					msgQ.push_back(decoderPkg::message'(m));
					failQ.push_back(f[0]);
				end
			end
		end
		$fclose(fd);
	endtask

	// Nothing may be requested or acknowledged while the inputs are quiet.
	task automatic checkQuiet(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			nextCycle();
			if (inAck !== 1'b0 || outReq !== 1'b0) begin
				otherCount++;
				$display("handshake output active at %0t ns with no request pending", $time);
			end
		end
	endtask

	task automatic sendWords();
		bit ok;
		foreach (wordQ[i]) begin
			waitForLevel(1'b0, 1'b0, "inAck", ok);
			if (!ok)
				return;
			inData = wordQ[i];
			inReq = 1'b1;
			nextCycle();
			waitForLevel(1'b0, 1'b1, "inAck", ok); // Withheld while full.
			if (!ok)
				return;
			sentCount++;
			inReq = 1'b0;
		end
	endtask

	task automatic receiveResults();
		bit ok;
		int delay;
		for (int i = 0; i < wordQ.size(); i++) begin
			waitForLevel(1'b1, 1'b1, "outReq", ok);
			if (!ok)
				return;
			gotCount++;
			checkMessage(i, msgQ[i], outMsg); // In input order.
			checkFail(i, failQ[i], outFail);
			delay = int'($urandom % 8);
			repeat (delay) nextCycle();
			outAck = 1'b1;
			nextCycle();
			waitForLevel(1'b1, 1'b0, "outReq", ok);
			if (!ok)
				return;
			outAck = 1'b0;
		end
	endtask

	always @(negedge clk) begin
		if (!rst && !overflowSeen && (sentCount - gotCount > MaxInFlight)) begin
			overflowSeen = 1'b1;
			otherCount++;
			$display("more than %0d words accepted and not yet returned at %0t ns",
				MaxInFlight, $time);
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		inReq = 1'b0;
		inData = '0;
		outAck = 1'b0;
		void'($urandom(32'hbdd5db15));
		readTrace();
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
		checkQuiet(20);
		if (wordQ.size() == 0) begin
			otherCount++;
			$display("no cases were read from the trace file");
		end else begin
			fork
				sendWords();
				receiveResults();
			join
			if (gotCount != wordQ.size()) begin
				otherCount++;
				$display("received %0d results for %0d cases", gotCount, wordQ.size());
			end
			checkQuiet(20); // No extra or repeated result.
		end
		$display("errors: %0d mismatches, %0d other failures, %0d of %0d cases returned",
			mismatchCount, otherCount, gotCount, wordQ.size());
		if (mismatchCount == 0 && otherCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* test/decode_trace.txt */
# Received word, expected message and expected failure flag, all in hex.
# One case per line, returned in this order.
0000 00 0
0537 01 0
0a6e 02 0
14dc 05 0
29b8 0a 0
5370 14 0
7fff 1f 0
5647 15 0
23d6 08 0
0536 01 0
4537 01 0
5770 14 0
0200 00 0
69b9 0a 0
7bfe 1f 0
1c9c 05 0
1246 15 0
0b7f 02 0
53d6 08 0
7ff8 1f 0
4401 00 0
67d6 08 0
000f 00 1
7d37 1f 1
29a7 0a 1
2f70 0b 1
17d3 05 1
7f80 1f 1
756e 1d 1
66b7 19 1
